// File: verilog/periph_pkg.sv
package periph_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [SEL_W-1:0]  sel_t;

   // Region code in addr[15:12]
   typedef logic [3:0] region_t;
   localparam region_t REGION_TIMER = 4'd0;
   localparam region_t REGION_GPIO  = 4'd1;

   // Word offset in addr[4:2]
   typedef logic [2:0] off_t;
   localparam off_t OFF_MTIME     = 3'd0;
   localparam off_t OFF_MTIMECMP  = 3'd1;
   localparam off_t OFF_GPIO_OUT  = 3'd0;
   localparam off_t OFF_GPIO_OE   = 3'd1;
   localparam off_t OFF_GPIO_IN   = 3'd2;
   localparam off_t OFF_GPIO_MASK = 3'd3;

   typedef struct packed {
      addr_t addr;
      data_t wdata;
      sel_t  sel;
      logic  we;
   } bus_req_t;

   typedef struct packed {
      data_t rdata;
      logic  err;
   } bus_rsp_t;

   typedef struct packed {
      off_t  off;
      data_t wdata;
      sel_t  sel;
      logic  we;
   } loc_req_t;

   typedef struct packed {
      logic timer;
      logic gpio;
   } irq_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_RESPOND
   } fsm_state_t;

   // Byte-lane write merge used by all register targets
   function automatic data_t merge_bytes(data_t old, data_t wdata, sel_t sel);
      data_t res;
      res = old;
      for (int i = 0; i < SEL_W; i++) begin
         if (sel[i]) begin
            res[i*8 +: 8] = wdata[i*8 +: 8];
         end
      end
      return res;
   endfunction

endpackage

// File: verilog/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
   parameter int REQ_DEPTH = 4
) (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_push,
   input  periph_pkg::bus_req_t i_data,
   input  logic                 i_pop,
   output periph_pkg::bus_req_t o_data,
   output logic                 o_empty
);

   localparam int PTR_W = $clog2(REQ_DEPTH);
   localparam int CNT_W = $clog2(REQ_DEPTH + 1);

   periph_pkg::bus_req_t mem [REQ_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;

   assign full    = count == CNT_W'(REQ_DEPTH);
   assign o_empty = count == '0;
   assign o_data  = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // Pointers wrap naturally as the depth is a power of two
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({i_push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Host spent more credits than it was given
   a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_push && full));

   a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_pop && o_empty));

endmodule

// File: verilog/bus_fsm.sv
`timescale 1ns/1ps

module bus_fsm #(
   parameter int REQ_DEPTH = 4
) (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_empty,
   input  periph_pkg::bus_req_t i_head,
   output logic                 o_pop,
   output logic                 o_credit,
   output periph_pkg::loc_req_t o_loc,
   output logic                 o_tmr_stb,
   output logic                 o_gpio_stb,
   input  periph_pkg::data_t    i_tmr_rdata,
   input  periph_pkg::data_t    i_gpio_rdata,
   output logic                 o_rsp_valid,
   output periph_pkg::bus_rsp_t o_rsp
);

   periph_pkg::fsm_state_t state_q;
   periph_pkg::fsm_state_t state_d;
   periph_pkg::bus_req_t   req_q;
   periph_pkg::region_t    region;
   logic                   hit_tmr;
   logic                   hit_gpio;
   logic                   err_q;

   //*******************************************************************
   // Region decode of the request in flight
   //*******************************************************************
   assign region   = req_q.addr[periph_pkg::ADDR_W-1 -: 4];
   assign hit_tmr  = region == periph_pkg::REGION_TIMER;
   assign hit_gpio = region == periph_pkg::REGION_GPIO;

   assign o_pop    = (state_q == periph_pkg::ST_IDLE) && !i_empty;
   assign o_credit = o_pop;

   assign o_loc.off   = req_q.addr[4:2];
   assign o_loc.wdata = req_q.wdata;
   assign o_loc.sel   = req_q.sel;
   assign o_loc.we    = req_q.we;

   assign o_tmr_stb  = (state_q == periph_pkg::ST_ACCESS) && hit_tmr;
   assign o_gpio_stb = (state_q == periph_pkg::ST_ACCESS) && hit_gpio;

   always_comb begin
      state_d = state_q;
      case (state_q)
         periph_pkg::ST_IDLE: begin
            if (!i_empty) begin
               state_d = periph_pkg::ST_ACCESS;
            end
         end
         periph_pkg::ST_ACCESS:  state_d = periph_pkg::ST_RESPOND;
         periph_pkg::ST_RESPOND: state_d = periph_pkg::ST_IDLE;
         default:                state_d = periph_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q     <= periph_pkg::ST_IDLE;
         o_rsp_valid <= 1'b0;
      end else begin
         state_q     <= state_d;
         o_rsp_valid <= state_q == periph_pkg::ST_RESPOND;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_pop) begin
         req_q <= i_head;
      end
      if (state_q == periph_pkg::ST_ACCESS) begin
         err_q <= !(hit_tmr || hit_gpio);
      end
      // Target data is valid the cycle after its strobe
      if (state_q == periph_pkg::ST_RESPOND) begin
         o_rsp.err   <= err_q;
         o_rsp.rdata <= err_q   ? '0 :
                        hit_tmr ? i_tmr_rdata : i_gpio_rdata;
      end
   end

   a_stb_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_tmr_stb && o_gpio_stb));

endmodule

// File: verilog/mtimer.sv
`timescale 1ns/1ps

module mtimer (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_stb,
   input  periph_pkg::loc_req_t i_loc,
   output periph_pkg::data_t    o_rdata,
   output logic                 o_irq
);

   periph_pkg::data_t mtime_q;
   periph_pkg::data_t mtimecmp_q;
   logic              wr_time;
   logic              wr_cmp;

   assign wr_time = i_stb && i_loc.we && (i_loc.off == periph_pkg::OFF_MTIME);
   assign wr_cmp  = i_stb && i_loc.we && (i_loc.off == periph_pkg::OFF_MTIMECMP);

   //*******************************************************************
   // Counter and compare
   //*******************************************************************
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtime_q    <= '0;
         mtimecmp_q <= '1;
      end else begin
         // A load replaces this cycle's increment
         if (wr_time) begin
            mtime_q <= periph_pkg::merge_bytes(mtime_q, i_loc.wdata, i_loc.sel);
         end else begin
            mtime_q <= mtime_q + 1'b1;
         end
         if (wr_cmp) begin
            mtimecmp_q <= periph_pkg::merge_bytes(mtimecmp_q, i_loc.wdata, i_loc.sel);
         end
      end
   end

   assign o_irq = mtime_q >= mtimecmp_q;

   always_ff @(posedge i_clk) begin
      if (i_stb) begin
         case (i_loc.off)
            periph_pkg::OFF_MTIME:    o_rdata <= mtime_q;
            periph_pkg::OFF_MTIMECMP: o_rdata <= mtimecmp_q;
            default:                  o_rdata <= '0;
         endcase
      end
   end

endmodule

// File: verilog/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs #(
   parameter int GPIO_W = 16
) (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_stb,
   input  periph_pkg::loc_req_t i_loc,
   output periph_pkg::data_t    o_rdata,
   input  logic [GPIO_W-1:0]    i_gpio_in,
   output logic [GPIO_W-1:0]    o_gpio_out,
   output logic [GPIO_W-1:0]    o_gpio_oe,
   output logic                 o_irq
);

   logic              wr;
   logic [GPIO_W-1:0] mask_q;
   logic [GPIO_W-1:0] sync_q1;
   logic [GPIO_W-1:0] sync_q2;
   periph_pkg::data_t out_ext;
   periph_pkg::data_t oe_ext;
   periph_pkg::data_t mask_ext;
   periph_pkg::data_t in_ext;

   assign wr = i_stb && i_loc.we;

   // Zero extended views so upper bits read as zero
   assign out_ext  = periph_pkg::data_t'(o_gpio_out);
   assign oe_ext   = periph_pkg::data_t'(o_gpio_oe);
   assign mask_ext = periph_pkg::data_t'(mask_q);
   assign in_ext   = periph_pkg::data_t'(sync_q2);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         mask_q     <= '0;
         sync_q1    <= '0;
         sync_q2    <= '0;
      end else begin
         sync_q1 <= i_gpio_in;
         sync_q2 <= sync_q1;
         if (wr && i_loc.off == periph_pkg::OFF_GPIO_OUT) begin
            o_gpio_out <= GPIO_W'(periph_pkg::merge_bytes(out_ext, i_loc.wdata, i_loc.sel));
         end
         if (wr && i_loc.off == periph_pkg::OFF_GPIO_OE) begin
            o_gpio_oe <= GPIO_W'(periph_pkg::merge_bytes(oe_ext, i_loc.wdata, i_loc.sel));
         end
         if (wr && i_loc.off == periph_pkg::OFF_GPIO_MASK) begin
            mask_q <= GPIO_W'(periph_pkg::merge_bytes(mask_ext, i_loc.wdata, i_loc.sel));
         end
      end
   end

   assign o_irq = |(sync_q2 & mask_q);

   always_ff @(posedge i_clk) begin
      if (i_stb) begin
         case (i_loc.off)
            periph_pkg::OFF_GPIO_OUT:  o_rdata <= out_ext;
            periph_pkg::OFF_GPIO_OE:   o_rdata <= oe_ext;
            periph_pkg::OFF_GPIO_IN:   o_rdata <= in_ext;
            periph_pkg::OFF_GPIO_MASK: o_rdata <= mask_ext;
            default:                   o_rdata <= '0;
         endcase
      end
   end

endmodule

// File: verilog/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
   parameter int REQ_DEPTH = 4,
   parameter int GPIO_W    = 16
) (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_req_valid,
   input  periph_pkg::bus_req_t i_req,
   output logic                 o_credit,
   output logic                 o_rsp_valid,
   output periph_pkg::bus_rsp_t o_rsp,
   input  logic [GPIO_W-1:0]    i_gpio_in,
   output logic [GPIO_W-1:0]    o_gpio_out,
   output logic [GPIO_W-1:0]    o_gpio_oe,
   output periph_pkg::irq_t     o_irq
);

   periph_pkg::bus_req_t head;
   periph_pkg::loc_req_t loc;
   periph_pkg::data_t    tmr_rdata;
   periph_pkg::data_t    gpio_rdata;
   logic                 empty;
   logic                 pop;
   logic                 tmr_stb;
   logic                 gpio_stb;

   req_fifo #(.REQ_DEPTH(REQ_DEPTH)) u_req_fifo (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (i_req_valid),
      .i_data  (i_req),
      .i_pop   (pop),
      .o_data  (head),
      .o_empty (empty)
   );

   bus_fsm #(.REQ_DEPTH(REQ_DEPTH)) u_bus_fsm (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_empty      (empty),
      .i_head       (head),
      .o_pop        (pop),
      .o_credit     (o_credit),
      .o_loc        (loc),
      .o_tmr_stb    (tmr_stb),
      .o_gpio_stb   (gpio_stb),
      .i_tmr_rdata  (tmr_rdata),
      .i_gpio_rdata (gpio_rdata),
      .o_rsp_valid  (o_rsp_valid),
      .o_rsp        (o_rsp)
   );

   mtimer u_mtimer (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_stb   (tmr_stb),
      .i_loc   (loc),
      .o_rdata (tmr_rdata),
      .o_irq   (o_irq.timer)
   );

   gpio_regs #(.GPIO_W(GPIO_W)) u_gpio_regs (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_stb      (gpio_stb),
      .i_loc      (loc),
      .o_rdata    (gpio_rdata),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_irq      (o_irq.gpio)
   );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic o_clk
);

   localparam realtime HALF_PERIOD = 2.0;

   // 4 ns period
   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD) o_clk = ~o_clk;
   end

endmodule

// File: dv/periph_tb.sv
`timescale 1ns/1ps

module periph_tb;

   localparam int REQ_DEPTH = 4;
   localparam int GPIO_W    = 16;

   localparam logic [1:0] OP_WR      = 2'd0;
   localparam logic [1:0] OP_RD      = 2'd1;
   localparam logic [1:0] OP_RD_NEAR = 2'd2;
   localparam logic [1:0] OP_PIN     = 2'd3;

   typedef struct packed {
      logic [1:0]        op;
      periph_pkg::addr_t addr;
      periph_pkg::data_t wdata;
      periph_pkg::sel_t  sel;
      periph_pkg::data_t exp_rdata;
      logic              exp_err;
      logic              chk_data;
      periph_pkg::irq_t  exp_irq;
      logic [GPIO_W-1:0] exp_out;
      logic [GPIO_W-1:0] exp_oe;
   } row_t;

   logic                 clk;
   logic                 rst_n;
   logic                 req_valid;
   periph_pkg::bus_req_t req;
   logic                 credit;
   logic                 rsp_valid;
   periph_pkg::bus_rsp_t rsp;
   logic [GPIO_W-1:0]    gpio_in;
   logic [GPIO_W-1:0]    gpio_out;
   logic [GPIO_W-1:0]    gpio_oe;
   periph_pkg::irq_t     irq;

   row_t  rows[$];
   string names[$];
   int    pend[$];
   int    credits;
   logic  credit_seen;
   logic  saw_no_credit;

   // Reference model of the registers
   periph_pkg::data_t m_time;
   periph_pkg::data_t m_cmp;
   logic [GPIO_W-1:0] m_out;
   logic [GPIO_W-1:0] m_oe;
   logic [GPIO_W-1:0] m_mask;
   logic [GPIO_W-1:0] m_in;
   logic [31:0]       rnd;

   tb_clk_gen u_clk_gen (.o_clk(clk));

   periph_top #(.REQ_DEPTH(REQ_DEPTH), .GPIO_W(GPIO_W)) u_dut (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_req_valid (req_valid),
      .i_req       (req),
      .o_credit    (credit),
      .o_rsp_valid (rsp_valid),
      .o_rsp       (rsp),
      .i_gpio_in   (gpio_in),
      .o_gpio_out  (gpio_out),
      .o_gpio_oe   (gpio_oe),
      .o_irq       (irq)
   );

   function automatic logic [31:0] xorshift32(logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic periph_pkg::data_t merge_lanes(periph_pkg::data_t old,
                                                     periph_pkg::data_t wd,
                                                     periph_pkg::sel_t sel);
      periph_pkg::data_t lane_mask;
      lane_mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      return (old & ~lane_mask) | (wd & lane_mask);
   endfunction

   task automatic abort_run();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(string name, string what,
                                  periph_pkg::data_t exp, periph_pkg::data_t act);
      $display("Error in %s, %s: expected %h, actual %h", name, what, exp, act);
      abort_run();
   endtask

   //*******************************************************************
   // Table build with expected values from the model
   //*******************************************************************
   task automatic push_row(string name, logic [1:0] op, periph_pkg::addr_t addr,
                           periph_pkg::data_t wd, periph_pkg::sel_t sel);
      row_t                r;
      periph_pkg::region_t region;
      periph_pkg::off_t    off;
      logic                wr;
      region      = addr[15:12];
      off         = addr[4:2];
      wr          = op == OP_WR;
      r.op        = op;
      r.addr      = addr;
      r.wdata     = wd;
      r.sel       = sel;
      r.exp_rdata = '0;
      r.exp_err   = (op != OP_PIN) && (region != periph_pkg::REGION_TIMER) &&
                    (region != periph_pkg::REGION_GPIO);
      if (op == OP_PIN) begin
         m_in = wd[GPIO_W-1:0];
      end else if (region == periph_pkg::REGION_TIMER) begin
         if (wr && off == periph_pkg::OFF_MTIME) begin
            m_time = wd;
         end else if (wr && off == periph_pkg::OFF_MTIMECMP) begin
            m_cmp = merge_lanes(m_cmp, wd, sel);
         end else if (!wr && off == periph_pkg::OFF_MTIME) begin
            r.exp_rdata = m_time;
         end else if (!wr && off == periph_pkg::OFF_MTIMECMP) begin
            r.exp_rdata = m_cmp;
         end
      end else if (region == periph_pkg::REGION_GPIO) begin
         if (wr) begin
            case (off)
               periph_pkg::OFF_GPIO_OUT:  m_out  = GPIO_W'(merge_lanes(32'(m_out), wd, sel));
               periph_pkg::OFF_GPIO_OE:   m_oe   = GPIO_W'(merge_lanes(32'(m_oe), wd, sel));
               periph_pkg::OFF_GPIO_MASK: m_mask = GPIO_W'(merge_lanes(32'(m_mask), wd, sel));
               default: ;
            endcase
         end else begin
            case (off)
               periph_pkg::OFF_GPIO_OUT:  r.exp_rdata = 32'(m_out);
               periph_pkg::OFF_GPIO_OE:   r.exp_rdata = 32'(m_oe);
               periph_pkg::OFF_GPIO_IN:   r.exp_rdata = 32'(m_in);
               periph_pkg::OFF_GPIO_MASK: r.exp_rdata = 32'(m_mask);
               default:                   r.exp_rdata = '0;
            endcase
         end
      end
      r.chk_data      = !wr || r.exp_err;
      // Counter lower bound against the compare value
      r.exp_irq.timer = m_time >= m_cmp;
      r.exp_irq.gpio  = |(m_in & m_mask);
      r.exp_out       = m_out;
      r.exp_oe        = m_oe;
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic check_outputs(int idx);
      row_t r;
      r = rows[idx];
      assert (irq == r.exp_irq) else report_mismatch(names[idx], "irq", r.exp_irq, irq);
      assert (gpio_out == r.exp_out) else
         report_mismatch(names[idx], "gpio_out", r.exp_out, gpio_out);
      assert (gpio_oe == r.exp_oe) else
         report_mismatch(names[idx], "gpio_oe", r.exp_oe, gpio_oe);
   endtask

   task automatic check_response();
      int   idx;
      row_t r;
      assert (pend.size() > 0) else begin
         $display("A response arrived with no request outstanding");
         abort_run();
      end
      idx = pend.pop_front();
      r   = rows[idx];
      assert (rsp.err == r.exp_err) else report_mismatch(names[idx], "err", r.exp_err, rsp.err);
      if (r.chk_data && r.op == OP_RD_NEAR) begin
         assert (rsp.rdata - r.exp_rdata <= 64) else
            report_mismatch(names[idx], "rdata lower bound", r.exp_rdata, rsp.rdata);
      end else if (r.chk_data) begin
         assert (rsp.rdata == r.exp_rdata) else
            report_mismatch(names[idx], "rdata", r.exp_rdata, rsp.rdata);
      end
      check_outputs(idx);
   endtask

   // Sampled on the falling edge
   // A returned credit becomes usable one cycle later
   task automatic next_cycle();
      @(negedge clk);
      if (credit_seen) begin
         credits++;
      end
      credit_seen = credit;
      assert (credits <= REQ_DEPTH) else begin
         $display("The credit count rose above the queue depth");
         abort_run();
      end
      if (rsp_valid) begin
         check_response();
      end
      req_valid = 1'b0;
   endtask

   task automatic issue_request(int idx);
      while (credits == 0) begin
         next_cycle();
      end
      req_valid = 1'b1;
      req.addr  = rows[idx].addr;
      req.wdata = rows[idx].wdata;
      req.sel   = rows[idx].sel;
      req.we    = rows[idx].op == OP_WR;
      credits--;
      if (credits == 0) begin
         saw_no_credit = 1'b1;
      end
      pend.push_back(idx);
      next_cycle();
   endtask

   task automatic wait_idle();
      while (pend.size() > 0) begin
         next_cycle();
      end
      repeat (2) next_cycle();
   endtask

   initial begin : watchdog
      int limit;
      @(posedge rst_n);
      limit = 40 * rows.size() + 100;
      repeat (limit) @(posedge clk);
      $display("The run did not finish within %0d cycles", limit);
      abort_run();
   end

   initial begin : main
      periph_pkg::data_t x;
      rst_n         = 1'b0;
      req_valid     = 1'b0;
      req           = '0;
      gpio_in       = '0;
      credits       = REQ_DEPTH;
      credit_seen   = 1'b0;
      saw_no_credit = 1'b0;
      m_time        = '0;
      m_cmp         = '1;
      m_out         = '0;
      m_oe          = '0;
      m_mask        = '0;
      m_in          = '0;
      rnd           = 32'had5e1f4c;

      //****************************************************************
      // Stimulus table
      //****************************************************************
      rnd = xorshift32(rnd);
      push_row("gpio_out_full", OP_WR, 16'h1000, rnd, 4'hf);
      rnd = xorshift32(rnd);
      push_row("gpio_oe_full", OP_WR, 16'h1004, rnd, 4'hf);
      push_row("gpio_out_rd", OP_RD, 16'h1000, '0, 4'hf);
      push_row("gpio_oe_rd", OP_RD, 16'h1004, '0, 4'hf);
      rnd = xorshift32(rnd);
      push_row("gpio_out_lo", OP_WR, 16'h1000, rnd, 4'h1);
      rnd = xorshift32(rnd);
      push_row("gpio_out_hi", OP_WR, 16'h1000, rnd, 4'ha);
      push_row("gpio_out_rd2", OP_RD, 16'h1000, '0, 4'hf);
      rnd = xorshift32(rnd);
      push_row("gpio_oe_mid", OP_WR, 16'h1004, rnd, 4'h6);
      push_row("gpio_oe_rd2", OP_RD, 16'h1004, '0, 4'hf);
      push_row("pins_a", OP_PIN, '0, 32'h0000_5a3c, '0);
      push_row("gpio_in_rd", OP_RD, 16'h1008, '0, 4'hf);
      push_row("mask_rd0", OP_RD, 16'h100c, '0, 4'hf);
      push_row("mask_set", OP_WR, 16'h100c, 32'h0000_0010, 4'h3);
      push_row("mask_rd", OP_RD, 16'h100c, '0, 4'hf);
      push_row("pins_b", OP_PIN, '0, 32'h0000_a5c3, '0);
      push_row("gpio_in_rd2", OP_RD, 16'h1008, '0, 4'hf);
      push_row("mask_clr", OP_WR, 16'h100c, '0, 4'hf);
      rnd = xorshift32(rnd);
      x   = (rnd & 32'h7fff_ff00) | 32'h0000_0100;
      push_row("mtime_wr", OP_WR, 16'h0000, x, 4'hf);
      push_row("mtime_rd", OP_RD_NEAR, 16'h0000, '0, 4'hf);
      push_row("mtimecmp_rd0", OP_RD, 16'h0004, '0, 4'hf);
      push_row("mtimecmp_low", OP_WR, 16'h0004, x >> 1, 4'hf);
      push_row("mtimecmp_rd", OP_RD, 16'h0004, '0, 4'hf);
      push_row("mtimecmp_max", OP_WR, 16'h0004, '1, 4'hf);
      push_row("mtimecmp_rd2", OP_RD, 16'h0004, '0, 4'hf);
      rnd = xorshift32(rnd);
      push_row("unmapped_wr", OP_WR, 16'h2004, rnd, 4'hf);
      rnd = xorshift32(rnd);
      push_row("unmapped_wr_out", OP_WR, 16'h3000, rnd, 4'hf);
      push_row("unmapped_rd", OP_RD, 16'hf004, '0, 4'hf);
      push_row("gpio_out_after", OP_RD, 16'h1000, '0, 4'hf);
      push_row("mtimecmp_after", OP_RD, 16'h0004, '0, 4'hf);
      push_row("gpio_unlisted", OP_RD, 16'h1014, '0, 4'hf);
      push_row("timer_unlisted", OP_RD, 16'h000c, '0, 4'hf);
      rnd = xorshift32(rnd);
      push_row("gpio_unlisted_wr", OP_WR, 16'h1018, rnd, 4'hf);
      push_row("gpio_oe_after", OP_RD, 16'h1004, '0, 4'hf);

      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      for (int i = 0; i < rows.size(); i++) begin
         if (rows[i].op == OP_PIN) begin
            wait_idle();
            gpio_in = rows[i].wdata[GPIO_W-1:0];
            // Two sync flops and some margin
            repeat (4) next_cycle();
            check_outputs(i);
         end else begin
            issue_request(i);
         end
      end

      wait_idle();
      repeat (6) next_cycle();
      assert (credits == REQ_DEPTH) else
         report_mismatch("credits_idle", "credit count", REQ_DEPTH, credits);
      assert (saw_no_credit) else begin
         $display("The credit count never reached zero during a burst");
         abort_run();
      end
      $display("All checks passed");
      $finish;
   end

endmodule

// File: periph_sub.f
verilog/periph_pkg.sv
verilog/req_fifo.sv
verilog/bus_fsm.sv
verilog/mtimer.sv
verilog/gpio_regs.sv
verilog/periph_top.sv
dv/tb_clk_gen.sv
dv/periph_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f periph_sub.f \
		--top-module periph_tb -Mdir obj_dir -o Vperiph_tb

# The log decides pass or fail
run: compile
	./obj_dir/Vperiph_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
